/* files.f */
+incdir+hw
hw/pipeline_types.sv
hw/pipe_stage.sv
hw/divider.sv
hw/ex.sv
hw/ex_top.sv
sim/tb_ex_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_ex_top -o tb_ex_top \
    && ./obj_dir/tb_ex_top | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/ex_trace.txt */
# aluop alusel reg1 reg2 inst llbit fwd_en fwd_val addr_ok_delay | expected: rd_data exc
# csr_en csr_data dc_valid dc_op dc_addr dc_wdata dc_wstrb (all hex)
01 1 f0f00000 00000f0f 00000000 0 0 00000000 0 f0f00f0f 0 0 00000000 0 0 00000000 00000000 0
02 1 ff00ff00 0ff00ff0 00000000 0 0 00000000 0 0f000f00 0 0 00000000 0 0 00000000 00000000 0
04 1 aaaaaaaa ffff0000 00000000 0 0 00000000 0 5555aaaa 0 0 00000000 0 0 00000000 00000000 0
08 2 00000001 0000003f 00000000 0 0 00000000 0 80000000 0 0 00000000 0 0 00000000 00000000 0
0a 2 f0000000 00000004 00000000 0 0 00000000 0 ff000000 0 0 00000000 0 0 00000000 00000000 0
10 3 7fffffff 00000001 00000000 0 0 00000000 0 80000000 0 0 00000000 0 0 00000000 00000000 0
11 3 00000005 00000007 00000000 0 0 00000000 0 fffffffe 0 0 00000000 0 0 00000000 00000000 0
12 3 ffffffff 00000001 00000000 0 0 00000000 0 00000001 0 0 00000000 0 0 00000000 00000000 0
13 3 ffffffff 00000001 00000000 0 0 00000000 0 00000000 0 0 00000000 0 0 00000000 00000000 0
14 3 00012345 00010000 00000000 0 0 00000000 0 23450000 0 0 00000000 0 0 00000000 00000000 0
15 3 ffffffff 00000002 00000000 0 0 00000000 0 ffffffff 0 0 00000000 0 0 00000000 00000000 0
16 3 ffffffff 00000002 00000000 0 0 00000000 0 00000001 0 0 00000000 0 0 00000000 00000000 0
18 3 fffffff9 00000002 00000000 0 0 00000000 0 fffffffd 0 0 00000000 0 0 00000000 00000000 0
1a 3 fffffff9 00000002 00000000 0 0 00000000 0 ffffffff 0 0 00000000 0 0 00000000 00000000 0
19 3 0000000a 00000000 00000000 0 0 00000000 0 ffffffff 0 0 00000000 0 0 00000000 00000000 0
28 4 00001000 000000ab 00000c00 0 0 00000000 2 00000000 0 0 00000000 1 1 00001003 abababab 8
29 4 00002000 0000beef 003ff800 0 0 00000000 0 00000000 0 0 00000000 1 1 00001ffe beefbeef c
2a 4 00003001 11111111 00000000 0 0 00000000 0 00000000 1 0 00000000 0 0 00000000 00000000 0
21 4 00004000 00000003 00000000 0 0 00000000 0 00000000 1 0 00000000 0 0 00000000 00000000 0
22 4 00004000 00000008 00000000 0 0 00000000 3 00000000 0 0 00000000 1 0 00004008 00000000 0
23 4 00005000 00000004 00000000 0 0 00000000 1 00000000 0 1 00000001 1 0 00005004 00000000 0
2b 4 00005000 cafef00d 00000400 0 1 00000001 1 00000001 0 1 00000000 1 1 00005004 cafef00d f
2b 4 00005000 cafef00d 00000400 1 1 00000000 0 00000000 0 0 00000000 0 0 00000000 00000000 0
2b 4 00006000 12345678 00000000 1 0 00000000 0 00000001 0 1 00000000 1 1 00006000 12345678 f

/* sim/tb_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module tb_ex_top;

    localparam int MAX_LINES = 64;

    logic clk;
    logic rst;
    logic dispatch_valid;
    logic llbit;
    logic dcache_addr_ok;
    logic mem_stall;
    logic stall;
    logic ex_mem_valid;
    pipeline_types::dispatch_ex_t dispatch_ex;
    pipeline_types::csr_forward_t mem_push_forward;
    pipeline_types::dcache_req_t  dcache_req;
    pipeline_types::ex_mem_t      ex_mem;

    // Trace columns
    logic [7:0]  t_op[MAX_LINES];
    logic [2:0]  t_sel[MAX_LINES];
    logic [31:0] t_reg1[MAX_LINES], t_reg2[MAX_LINES], t_inst[MAX_LINES];
    logic        t_llbit[MAX_LINES], t_fwd_en[MAX_LINES];
    logic [31:0] t_fwd_val[MAX_LINES], t_delay[MAX_LINES], t_data[MAX_LINES];
    logic        t_exc[MAX_LINES], t_csr_en[MAX_LINES];
    logic [31:0] t_csr_data[MAX_LINES];
    logic        t_dcv[MAX_LINES], t_dcop[MAX_LINES], dc_seen[MAX_LINES];
    logic [31:0] t_dcaddr[MAX_LINES], t_dcwdata[MAX_LINES];
    logic [3:0]  t_dcwstrb[MAX_LINES];

    int n_lines = 0;
    int ex_mem_errors = 0;
    int dcache_errors = 0;
    int other_errors = 0;
    int exp_q[$];

    ex_top DUT (
        .clk(clk),
        .rst(rst),
        .dispatch_ex(dispatch_ex),
        .dispatch_valid(dispatch_valid),
        .llbit(llbit),
        .mem_push_forward(mem_push_forward),
        .dcache_addr_ok(dcache_addr_ok),
        .mem_stall(mem_stall),
        .dcache_req(dcache_req),
        .stall(stall),
        .ex_mem(ex_mem),
        .ex_mem_valid(ex_mem_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic pipeline_types::dispatch_ex_t make_dispatch(input int i);
        pipeline_types::dispatch_ex_t d;
        d.pc = 32'(i) << 2;    // pc tags program order
        d.inst = t_inst[i];
        d.reg1 = t_reg1[i];
        d.reg2 = t_reg2[i];
        d.aluop = t_op[i];
        d.alusel = t_sel[i];
        d.reg_write_en = 1'b1;
        d.reg_write_addr = 5'(i);
        return d;
    endfunction

    function automatic pipeline_types::ex_mem_t expected_ex_mem(input int i);
        pipeline_types::ex_mem_t e;
        e = '0;
        e.pc = 32'(i) << 2;
        e.aluop = t_op[i];
        e.reg_write_en = 1'b1;
        e.reg_write_addr = 5'(i);
        e.reg_write_data = t_data[i];
        e.mem_addr = t_dcaddr[i];
        e.is_exception = t_exc[i];
        e.exception_cause = t_exc[i] ? `EXCEPTION_ALE : 7'd0;
        e.csr_write_en = t_csr_en[i];
        e.csr_addr = t_csr_en[i] ? `CSR_LLBCTL : 14'd0;
        e.csr_write_data = t_csr_data[i];
        e.is_llw_scw = t_csr_en[i];    // ll.w or an sc.w that holds the link
        return e;
    endfunction

    function automatic pipeline_types::dcache_req_t expected_dcache(input int i);
        pipeline_types::dcache_req_t e;
        e.valid = t_dcv[i];
        e.op = t_dcop[i];
        e.virtual_addr = t_dcaddr[i];
        e.wdata = t_dcwdata[i];
        e.wstrb = t_dcwstrb[i];
        return e;
    endfunction

    task automatic check_ex_mem(input pipeline_types::ex_mem_t got,
                                input pipeline_types::ex_mem_t exp,
                                input logic check_addr);
        if (got.pc !== exp.pc || got.reg_write_data !== exp.reg_write_data) begin
            ex_mem_errors++;
            $display("** Error at %0t: ex_mem pc %h data %h, expected pc %h data %h",
                     $time, got.pc, got.reg_write_data, exp.pc, exp.reg_write_data);
        end
        if (got.aluop !== exp.aluop || got.reg_write_en !== exp.reg_write_en ||
            got.reg_write_addr !== exp.reg_write_addr ||
            got.is_llw_scw !== exp.is_llw_scw ||
            (check_addr && got.mem_addr !== exp.mem_addr)) begin
            ex_mem_errors++;
            $display("** Error at %0t: pc %h op %h wen %b rd %0d llsc %b addr %h", $time,
                     exp.pc, got.aluop, got.reg_write_en, got.reg_write_addr,
                     got.is_llw_scw, got.mem_addr);
            $display("    expected op %h wen %b rd %0d llsc %b addr %h",
                     exp.aluop, exp.reg_write_en, exp.reg_write_addr,
                     exp.is_llw_scw, exp.mem_addr);
        end
        if (got.is_exception !== exp.is_exception ||
            got.exception_cause !== exp.exception_cause) begin
            ex_mem_errors++;
            $display("** Error at %0t: pc %h exception %b/%h, expected %b/%h", $time,
                     exp.pc, got.is_exception, got.exception_cause,
                     exp.is_exception, exp.exception_cause);
        end
        if (got.csr_write_en !== exp.csr_write_en ||
            (exp.csr_write_en && (got.csr_addr !== exp.csr_addr ||
                                  got.csr_write_data !== exp.csr_write_data))) begin
            ex_mem_errors++;
            $display("** Error at %0t: pc %h csr write %b %h %h, expected %b %h %h", $time,
                     exp.pc, got.csr_write_en, got.csr_addr, got.csr_write_data,
                     exp.csr_write_en, exp.csr_addr, exp.csr_write_data);
        end
    endtask

    task automatic check_dcache(input pipeline_types::dcache_req_t got,
                                input pipeline_types::dcache_req_t exp);
        // Data and strobes only matter for writes
        if (got.op !== exp.op || got.virtual_addr !== exp.virtual_addr ||
            (exp.op && (got.wdata !== exp.wdata || got.wstrb !== exp.wstrb))) begin
            dcache_errors++;
            $display("** Error at %0t: dcache op %b addr %h wdata %h wstrb %h, expected %b %h %h %h",
                     $time, got.op, got.virtual_addr, got.wdata, got.wstrb,
                     exp.op, exp.virtual_addr, exp.wdata, exp.wstrb);
        end
    endtask

    task automatic read_trace();
        int fd;
        int i;
        string line;
        fd = $fopen("sim/ex_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the trace file sim/ex_trace.txt");
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line.getc(0) == "#") continue;
            i = n_lines;
            void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          t_op[i], t_sel[i], t_reg1[i], t_reg2[i], t_inst[i], t_llbit[i],
                          t_fwd_en[i], t_fwd_val[i], t_delay[i], t_data[i], t_exc[i],
                          t_csr_en[i], t_csr_data[i], t_dcv[i], t_dcop[i], t_dcaddr[i],
                          t_dcwdata[i], t_dcwstrb[i]));
            dc_seen[i] = 1'b0;
            n_lines++;
        end
        $fclose(fd);
    endtask

    initial begin
        int pend;
        int cur;
        int age;
        int idx;
        int done_cnt;
        int cycles;
        int limit;
        int burst;
        logic prev_ms;
        logic [31:0] seed;

        rst = 1'b1;
        dispatch_ex = '0;
        dispatch_valid = 1'b0;
        llbit = 1'b0;
        mem_push_forward = '0;
        dcache_addr_ok = 1'b0;
        mem_stall = 1'b0;
        pend = 0;
        cur = -1;
        age = 0;
        done_cnt = 0;
        cycles = 0;
        burst = 0;
        prev_ms = 1'b0;
        seed = 32'hce17;

        read_trace();
        limit = n_lines * 40 + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (other_errors == 0 && done_cnt < n_lines && cycles < limit) begin
            seed = lcg_next(seed);
            if (burst > 0) begin
                mem_stall = 1'b1;
                burst--;
            end
            else if (seed[20:18] == 3'd0) begin    // Start a burst of 1 to 4 cycles
                mem_stall = 1'b1;
                burst = int'(seed[17:16]);
            end
            else mem_stall = 1'b0;

            dispatch_valid = pend < n_lines;
            dispatch_ex = (pend < n_lines) ? make_dispatch(pend) : '0;
            if (cur >= 0) begin
                llbit = t_llbit[cur];
                mem_push_forward.write_en = t_fwd_en[cur];
                mem_push_forward.write_addr = `CSR_LLBCTL;
                mem_push_forward.write_data = t_fwd_val[cur];
                dcache_addr_ok = age >= int'(t_delay[cur]);
            end
            else begin
                llbit = 1'b0;
                mem_push_forward = '0;
                dcache_addr_ok = 1'b0;
            end

            #1;
            // Output register changed only if mem_stall was low at the last edge
            if (ex_mem_valid && !prev_ms) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Result at %0t arrived with no instruction outstanding", $time);
                end
                else begin
                    idx = exp_q.pop_front();
                    check_ex_mem(ex_mem, expected_ex_mem(idx), t_dcv[idx]);
                    if (t_dcv[idx] && !dc_seen[idx]) begin
                        other_errors++;
                        $display("Instruction %0d left without its dcache request", idx);
                    end
                    done_cnt++;
                end
            end
            if (dcache_req.valid) begin
                if (cur < 0 || !t_dcv[cur]) begin
                    other_errors++;
                    $display("Unexpected dcache request at %0t", $time);
                end
                else if (dcache_addr_ok) begin
                    check_dcache(dcache_req, expected_dcache(cur));
                    dc_seen[cur] = 1'b1;
                end
            end
            if (!stall) begin
                cur = (pend < n_lines) ? pend : -1;
                if (pend < n_lines) begin
                    exp_q.push_back(pend);
                    pend++;
                end
                age = 0;
            end
            else age++;
            prev_ms = mem_stall;
            cycles++;
            @(negedge clk);
        end

        if (done_cnt < n_lines) begin
            other_errors++;
            $display("Timed out after %0d cycles with %0d of %0d results", cycles,
                     done_cnt, n_lines);
        end
        $display("Errors: %0d ex_mem, %0d dcache, %0d other; %0d results checked",
                 ex_mem_errors, dcache_errors, other_errors, done_cnt);
        if (ex_mem_errors + dcache_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire pipeline_types::dispatch_ex_t dispatch_ex,
    input  wire logic                         dispatch_valid,
    input  wire logic                         llbit,
    input  wire pipeline_types::csr_forward_t mem_push_forward,
    input  wire logic                         dcache_addr_ok,
    input  wire logic                         mem_stall,
    output pipeline_types::dcache_req_t       dcache_req,
    output logic                              stall,
    output pipeline_types::ex_mem_t           ex_mem,
    output logic                              ex_mem_valid
);

    pipeline_types::dispatch_ex_t cur_dispatch;
    pipeline_types::ex_mem_t      ex_result;
    pipeline_types::div_req_t     div_req;
    pipeline_types::div_rsp_t     div_rsp;
    logic                         cur_valid;
    logic                         pause;

    assign stall = pause | mem_stall;

    pipe_stage #(.payload_t(pipeline_types::dispatch_ex_t)) u_in_stage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .in_valid(dispatch_valid),
        .in_data(dispatch_ex),
        .out_valid(cur_valid),
        .out_data(cur_dispatch)
    );

    ex u_ex (
        .dispatch_ex(cur_dispatch),
        .llbit(llbit),
        .mem_push_forward(mem_push_forward),
        .dcache_addr_ok(dcache_addr_ok),
        .div_rsp(div_rsp),
        .dcache_req(dcache_req),
        .div_req(div_req),
        .pause(pause),
        .ex_mem(ex_result)
    );

    divider u_divider (
        .clk(clk),
        .rst(rst),
        .div_req(div_req),
        .div_rsp(div_rsp)
    );

    // Paused instruction leaves bubbles
    pipe_stage #(.payload_t(pipeline_types::ex_mem_t)) u_out_stage (
        .clk(clk),
        .rst(rst),
        .stall(mem_stall),
        .in_valid(cur_valid & ~pause),
        .in_data(ex_result),
        .out_valid(ex_mem_valid),
        .out_data(ex_mem)
    );

endmodule

`default_nettype wire

/* hw/ex.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module ex (
    input  wire pipeline_types::dispatch_ex_t dispatch_ex,
    input  wire logic                         llbit,
    input  wire pipeline_types::csr_forward_t mem_push_forward,
    input  wire logic                         dcache_addr_ok,
    input  wire pipeline_types::div_rsp_t     div_rsp,
    output pipeline_types::dcache_req_t       dcache_req,
    output pipeline_types::div_req_t          div_req,
    output logic                              pause,
    output pipeline_types::ex_mem_t           ex_mem
);

    pipeline_types::bus32_t reg1;
    pipeline_types::bus32_t reg2;
    pipeline_types::bus32_t logic_res;
    pipeline_types::bus32_t shift_res;
    pipeline_types::bus32_t arith_res;
    pipeline_types::bus32_t sum_res;
    pipeline_types::bus32_t mem_addr;
    pipeline_types::bus64_t mul_a;
    pipeline_types::bus64_t mul_b;
    pipeline_types::bus64_t mul_prod;
    logic [11:0] si12;
    logic [13:0] si14;
    logic        mul_signed;
    logic        llbit_current;
    logic        mem_valid;
    logic        misaligned;
    logic        is_div;

    assign reg1 = dispatch_ex.reg1;
    assign reg2 = dispatch_ex.reg2;
    assign si12 = dispatch_ex.inst[21:10];
    assign si14 = dispatch_ex.inst[23:10];

    // LLBCTL write in mem overrides the architectural bit
    assign llbit_current = (mem_push_forward.write_en &&
                            mem_push_forward.write_addr == `CSR_LLBCTL) ?
                           mem_push_forward.write_data[0] : llbit;

    always_comb begin
        case (dispatch_ex.aluop)
            `ALU_ORI: logic_res = reg1 | reg2;
            `ALU_AND: logic_res = reg1 & reg2;
            `ALU_NOR: logic_res = ~(reg1 | reg2);
            `ALU_XOR: logic_res = reg1 ^ reg2;
            default:  logic_res = '0;
        endcase
    end

    always_comb begin
        case (dispatch_ex.aluop)
            `ALU_SLLW: shift_res = reg1 << reg2[4:0];
            `ALU_SRLW: shift_res = reg1 >> reg2[4:0];
            `ALU_SRAW: shift_res = $signed(reg1) >>> reg2[4:0];
            default:   shift_res = '0;
        endcase
    end

    assign sum_res = (dispatch_ex.aluop == `ALU_SUBW) ? reg1 - reg2 : reg1 + reg2;

    // Low half of the product is the same signed or unsigned
    assign mul_signed = dispatch_ex.aluop != `ALU_MULHWU;
    assign mul_a = {mul_signed ? {`XLEN{reg1[31]}} : {`XLEN{1'b0}}, reg1};
    assign mul_b = {mul_signed ? {`XLEN{reg2[31]}} : {`XLEN{1'b0}}, reg2};
    assign mul_prod = mul_a * mul_b;

    always_comb begin
        case (dispatch_ex.aluop)
            `ALU_ADDW, `ALU_SUBW:  arith_res = sum_res;
            `ALU_SLT:              arith_res = {31'b0, $signed(reg1) < $signed(reg2)};
            `ALU_SLTU:             arith_res = {31'b0, reg1 < reg2};
            `ALU_MULW:             arith_res = mul_prod[31:0];
            `ALU_MULHW, `ALU_MULHWU: arith_res = mul_prod[63:32];
            `ALU_DIVW, `ALU_DIVWU: arith_res = div_rsp.result[31:0];
            `ALU_MODW, `ALU_MODWU: arith_res = div_rsp.result[63:32];
            default:               arith_res = '0;
        endcase
    end

    always_comb begin
        case (dispatch_ex.aluop)
            `ALU_LDB, `ALU_LDH, `ALU_LDW, `ALU_LLW: mem_addr = reg1 + reg2;
            `ALU_STB, `ALU_STH, `ALU_STW: mem_addr = reg1 + {{20{si12[11]}}, si12};
            `ALU_SCW: mem_addr = reg1 + {{16{si14[13]}}, si14, 2'b00};
            default:  mem_addr = '0;
        endcase
    end

    always_comb begin
        mem_valid = 1'b0;
        misaligned = 1'b0;
        dcache_req.op = 1'b0;
        dcache_req.wdata = '0;
        dcache_req.wstrb = 4'b1111;
        dcache_req.virtual_addr = mem_addr;
        case (dispatch_ex.aluop)
            `ALU_LDB: mem_valid = 1'b1;
            `ALU_LDH: begin
                mem_valid = 1'b1;
                misaligned = mem_addr[0];
            end
            `ALU_LDW, `ALU_LLW: begin
                mem_valid = 1'b1;
                misaligned = |mem_addr[1:0];
            end
            `ALU_STB: begin
                mem_valid = 1'b1;
                dcache_req.op = 1'b1;
                dcache_req.wdata = {4{reg2[7:0]}};
                dcache_req.wstrb = 4'b0001 << mem_addr[1:0];
            end
            `ALU_STH: begin
                mem_valid = 1'b1;
                misaligned = mem_addr[0];
                dcache_req.op = 1'b1;
                dcache_req.wdata = {2{reg2[15:0]}};
                dcache_req.wstrb = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            `ALU_STW: begin
                mem_valid = 1'b1;
                misaligned = |mem_addr[1:0];
                dcache_req.op = 1'b1;
                dcache_req.wdata = reg2;
            end
            `ALU_SCW: begin
                misaligned = |mem_addr[1:0];
                if (llbit_current) begin    // store only while the link holds
                    mem_valid = 1'b1;
                    dcache_req.op = 1'b1;
                    dcache_req.wdata = reg2;
                end
            end
            default: mem_valid = 1'b0;
        endcase
        dcache_req.valid = mem_valid && !misaligned;
    end

    assign is_div = dispatch_ex.aluop == `ALU_DIVW || dispatch_ex.aluop == `ALU_DIVWU ||
                    dispatch_ex.aluop == `ALU_MODW || dispatch_ex.aluop == `ALU_MODWU;

    always_comb begin
        div_req.start = is_div && !div_rsp.done;
        div_req.is_signed = dispatch_ex.aluop == `ALU_DIVW || dispatch_ex.aluop == `ALU_MODW;
        div_req.dividend = reg1;
        div_req.divisor = reg2;
    end

    assign pause = (dcache_req.valid && !dcache_addr_ok) || (is_div && !div_rsp.done);

    always_comb begin
        ex_mem.pc = dispatch_ex.pc;
        ex_mem.aluop = dispatch_ex.aluop;
        ex_mem.reg_write_en = dispatch_ex.reg_write_en;
        ex_mem.reg_write_addr = dispatch_ex.reg_write_addr;
        case (dispatch_ex.alusel)
            `ALU_SEL_LOGIC:      ex_mem.reg_write_data = logic_res;
            `ALU_SEL_SHIFT:      ex_mem.reg_write_data = shift_res;
            `ALU_SEL_ARITHMETIC: ex_mem.reg_write_data = arith_res;
            `ALU_SEL_LOAD_STORE: begin
                // sc.w returns its success flag in rd
                ex_mem.reg_write_data = (dispatch_ex.aluop == `ALU_SCW) ?
                                        {31'b0, llbit_current} : '0;
            end
            default: ex_mem.reg_write_data = '0;
        endcase
        ex_mem.mem_addr = mem_addr;
        ex_mem.is_exception = misaligned;
        ex_mem.exception_cause = misaligned ? `EXCEPTION_ALE : 7'b0;
        ex_mem.csr_write_en = 1'b0;
        ex_mem.csr_addr = '0;
        ex_mem.csr_write_data = '0;
        ex_mem.is_llw_scw = 1'b0;
        if (dispatch_ex.aluop == `ALU_LLW) begin
            ex_mem.csr_write_en = 1'b1;
            ex_mem.csr_addr = `CSR_LLBCTL;
            ex_mem.csr_write_data = 32'd1;
            ex_mem.is_llw_scw = 1'b1;
        end
        else if (dispatch_ex.aluop == `ALU_SCW && llbit_current) begin
            ex_mem.csr_write_en = 1'b1;    // link consumed
            ex_mem.csr_addr = `CSR_LLBCTL;
            ex_mem.is_llw_scw = 1'b1;
        end
    end

    // A divider response belongs to the divide held in this stage
    always_comb begin
        if (div_rsp.done) begin
            a_done_only_for_div: assert (is_div)
                else $error("divider done without a divide in execute");
        end
    end

endmodule

`default_nettype wire

/* hw/divider.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ex_consts.svh"

module divider (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire pipeline_types::div_req_t div_req,
    output pipeline_types::div_rsp_t      div_rsp
);

    typedef enum logic [1:0] {IDLE, BUSY, SIGN, DONE} state_t;

    state_t                 state;
    logic [4:0]             cnt;
    pipeline_types::bus32_t quo;
    pipeline_types::bus32_t rem;
    pipeline_types::bus32_t dsr;
    logic                   neg_q;
    logic                   neg_r;
    logic [`XLEN:0]         shifted;
    logic [`XLEN:0]         diff;

    assign shifted = {rem, quo[`XLEN-1]};
    assign diff = shifted - {1'b0, dsr};    // borrow in the top bit

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt <= '0;
        end
        else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (div_req.start) state <= BUSY;
                end
                BUSY: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(`XLEN - 1)) state <= SIGN;
                end
                SIGN: state <= DONE;
                default: state <= IDLE;    // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                quo <= (div_req.is_signed && div_req.dividend[31]) ?
                       -div_req.dividend : div_req.dividend;
                dsr <= (div_req.is_signed && div_req.divisor[31]) ?
                       -div_req.divisor : div_req.divisor;
                rem <= '0;
                // Zero divisor keeps quotient all ones
                neg_q <= div_req.is_signed && (div_req.dividend[31] ^ div_req.divisor[31]) &&
                         (|div_req.divisor);
                neg_r <= div_req.is_signed && div_req.dividend[31];
            end
            BUSY: begin
                if (!diff[`XLEN]) begin
                    rem <= diff[`XLEN-1:0];
                    quo <= {quo[`XLEN-2:0], 1'b1};
                end
                else begin
                    rem <= shifted[`XLEN-1:0];
                    quo <= {quo[`XLEN-2:0], 1'b0};
                end
            end
            SIGN: begin
                if (neg_q) quo <= -quo;
                if (neg_r) rem <= -rem;
            end
            default: quo <= quo;
        endcase
    end

    always_comb begin
        div_rsp.done = state == DONE;
        div_rsp.result = {rem, quo};
    end

    // Requester holds start for the whole run
    a_start_held: assert property (@(posedge clk) disable iff (rst)
        (state == BUSY || state == SIGN) |-> div_req.start)
        else $error("divider start dropped during a run");

endmodule

`default_nettype wire

/* hw/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data <= '0;
        end
        else if (!stall) begin
            out_valid <= in_valid;
            out_data <= in_data;
        end
    end

    // Nothing leaves the stage right after reset
    a_valid_after_rst: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("pipe_stage valid set after reset");

endmodule

`default_nettype wire

/* hw/pipeline_types.sv */
`default_nettype none
`include "ex_consts.svh"

package pipeline_types;

    typedef logic [`XLEN-1:0] bus32_t;
    typedef logic [2*`XLEN-1:0] bus64_t;

    typedef struct packed {
        bus32_t     pc;
        bus32_t     inst;
        bus32_t     reg1;
        bus32_t     reg2;
        logic [7:0] aluop;
        logic [2:0] alusel;
        logic       reg_write_en;
        logic [4:0] reg_write_addr;
    } dispatch_ex_t;

    typedef struct packed {
        bus32_t      pc;
        logic [7:0]  aluop;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        bus32_t      reg_write_data;
        bus32_t      mem_addr;
        logic        is_exception;
        logic [6:0]  exception_cause;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        bus32_t      csr_write_data;
        logic        is_llw_scw;
    } ex_mem_t;

    // CSR write still in the memory stage
    typedef struct packed {
        logic        write_en;
        logic [13:0] write_addr;
        bus32_t      write_data;
    } csr_forward_t;

    typedef struct packed {
        logic       valid;
        logic       op;    // 1 = write
        bus32_t     virtual_addr;
        bus32_t     wdata;
        logic [3:0] wstrb;
    } dcache_req_t;

    typedef struct packed {
        logic   start;
        logic   is_signed;
        bus32_t dividend;
        bus32_t divisor;
    } div_req_t;

    typedef struct packed {
        logic   done;
        bus64_t result;    // {remainder, quotient}
    } div_rsp_t;

endpackage

`default_nettype wire

/* hw/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN 32

// Logic ops
`define ALU_ORI    8'h01
`define ALU_AND    8'h02
`define ALU_NOR    8'h03
`define ALU_XOR    8'h04

`define ALU_SLLW   8'h08
`define ALU_SRLW   8'h09
`define ALU_SRAW   8'h0a

`define ALU_ADDW   8'h10
`define ALU_SUBW   8'h11
`define ALU_SLT    8'h12
`define ALU_SLTU   8'h13
`define ALU_MULW   8'h14
`define ALU_MULHW  8'h15
`define ALU_MULHWU 8'h16
`define ALU_DIVW   8'h18
`define ALU_DIVWU  8'h19
`define ALU_MODW   8'h1a
`define ALU_MODWU  8'h1b

`define ALU_LDB    8'h20
`define ALU_LDH    8'h21
`define ALU_LDW    8'h22
`define ALU_LLW    8'h23
`define ALU_STB    8'h28
`define ALU_STH    8'h29
`define ALU_STW    8'h2a
`define ALU_SCW    8'h2b

// Result groups
`define ALU_SEL_LOGIC      3'b001
`define ALU_SEL_SHIFT      3'b010
`define ALU_SEL_ARITHMETIC 3'b011
`define ALU_SEL_LOAD_STORE 3'b100

`define CSR_LLBCTL    14'h060
`define EXCEPTION_ALE 7'h09

`endif
